// File: verilog/router_pkg.sv
// router package: port numbering, port count and the shared port index/vector types
package router_pkg;

   //--------------------------------------------------
   // port count and index width
   //--------------------------------------------------

   // two mesh dimensions, two neighbors each, plus one local node
   localparam int NUM_PORTS = 5;

   // bits needed to name one port
   localparam int PORT_IDX_WIDTH = $clog2(NUM_PORTS);

   //--------------------------------------------------
   // shared types
   //--------------------------------------------------

   // index of a single port
   typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;

   // one bit per port, for requests, grants and lock masks
   typedef logic [NUM_PORTS-1:0] port_vec_t;

   //--------------------------------------------------
   // port numbering
   //--------------------------------------------------

   // x dimension neighbors
   localparam port_idx_t PORT_XNEG = 3'd0;
   localparam port_idx_t PORT_XPOS = 3'd1;

   // y dimension neighbors
   localparam port_idx_t PORT_YNEG = 3'd2;
   localparam port_idx_t PORT_YPOS = 3'd3;

   // injection / ejection port of the attached node
   localparam port_idx_t PORT_LOCAL = 3'd4;

endpackage

// File: verilog/input_port.sv
// router input port: flit FIFO, x-first route computation and credit return
module input_port
  #(parameter int flit_data_width = 32,
    parameter int buffer_size = 4,
    parameter int dim_addr_width = 2)
   (input  logic                       clk,
    input  logic                       rst,
    input  logic [dim_addr_width-1:0]  router_x,
    input  logic [dim_addr_width-1:0]  router_y,
    input  logic                       in_valid,
    input  logic                       in_head,
    input  logic                       in_tail,
    input  logic [flit_data_width-1:0] in_data,
    input  logic                       grant,
    output router_pkg::port_vec_t      request,
    output logic                       head_flit,
    output logic                       tail_flit,
    output logic [flit_data_width-1:0] flit_data,
    output logic                       credit_out);

   import router_pkg::*;

   // destination address sits in the low bits of a head flit
   localparam int router_addr_width = 2 * dim_addr_width;
   localparam int ptr_width = (buffer_size > 1) ? $clog2(buffer_size) : 1;
   localparam int cnt_width = $clog2(buffer_size + 1);

   //--------------------------------------------------
   // flit buffer
   //--------------------------------------------------

   // payload and framing storage
   logic [flit_data_width-1:0] data_mem [buffer_size];
   logic [buffer_size-1:0]     head_mem;
   logic [buffer_size-1:0]     tail_mem;

   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   logic [cnt_width-1:0] fill;
   logic                 empty;
   logic                 full;
   logic                 deq;

   // circular wrap, buffer_size need not be a power of two
   function automatic logic [ptr_width-1:0] ptr_next(logic [ptr_width-1:0] ptr);
      return (ptr == ptr_width'(buffer_size - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign empty = (fill == '0);
   assign full  = (fill == cnt_width'(buffer_size));

   // a grant always pops the flit currently at the head
   assign deq = grant && !empty;

   always_ff @(posedge clk)
   begin
      if (in_valid)
      begin
         data_mem[wr_ptr] <= in_data;
         head_mem[wr_ptr] <= in_head;
         tail_mem[wr_ptr] <= in_tail;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end
      else
      begin
         if (in_valid)
            wr_ptr <= ptr_next(wr_ptr);
         if (deq)
            rd_ptr <= ptr_next(rd_ptr);
         // occupancy only moves when exactly one side is active
         if (in_valid && !deq)
            fill <= fill + 1'b1;
         else if (!in_valid && deq)
            fill <= fill - 1'b1;
      end
   end

   // head of fifo goes straight to the crossbar
   assign flit_data = data_mem[rd_ptr];
   assign head_flit = !empty && head_mem[rd_ptr];
   assign tail_flit = !empty && tail_mem[rd_ptr];

   //--------------------------------------------------
   // dimension-order routing
   //--------------------------------------------------

   logic [router_addr_width-1:0] dest_addr;
   logic [dim_addr_width-1:0]    dest_x;
   logic [dim_addr_width-1:0]    dest_y;
   port_vec_t                    route_calc;
   port_vec_t                    route_q;

   assign dest_addr = flit_data[router_addr_width-1:0];
   assign dest_x    = dest_addr[dim_addr_width-1:0];
   assign dest_y    = dest_addr[router_addr_width-1:dim_addr_width];

   // resolve x first, then y, then eject
   always_comb
   begin
      if (dest_x > router_x)
         route_calc = port_vec_t'(1) << PORT_XPOS;
      else if (dest_x < router_x)
         route_calc = port_vec_t'(1) << PORT_XNEG;
      else if (dest_y > router_y)
         route_calc = port_vec_t'(1) << PORT_YPOS;
      else if (dest_y < router_y)
         route_calc = port_vec_t'(1) << PORT_YNEG;
      else
         route_calc = port_vec_t'(1) << PORT_LOCAL;
   end

   // body and tail flits reuse the route of their head
   always_ff @(posedge clk)
   begin
      if (rst)
         route_q <= '0;
      else if (deq && head_flit)
         route_q <= route_calc;
   end

   assign request = empty ? '0 : (head_flit ? route_calc : route_q);

   //--------------------------------------------------
   // credit return
   //--------------------------------------------------

   // one registered pulse per freed slot
   always_ff @(posedge clk)
   begin
      if (rst)
         credit_out <= 1'b0;
      else
         credit_out <= deq;
   end

   //--------------------------------------------------
   // checks
   //--------------------------------------------------

   // framing tracker, next arriving flit must open a packet
   logic expect_head;

   always_ff @(posedge clk)
   begin
      if (rst)
         expect_head <= 1'b1;
      else if (in_valid)
         expect_head <= in_tail;
   end

   // upstream must never exceed the credits it was given
   a_no_overflow: assert property (@(posedge clk) disable iff (rst) in_valid |-> !full)
      else $error("flit written into a full input buffer");

   a_head_after_tail: assert property (@(posedge clk) disable iff (rst)
                                       in_valid && expect_head |-> in_head)
      else $error("packet started without a head flit");

endmodule

// File: verilog/switch_alloc.sv
// switch allocator: round-robin per-output arbitration, held for the whole packet
module switch_alloc
   (input  logic                  clk,
    input  logic                  rst,
    input  router_pkg::port_vec_t request [router_pkg::NUM_PORTS],
    input  router_pkg::port_vec_t tail_flit,
    input  router_pkg::port_vec_t credit_ok,
    output router_pkg::port_vec_t grant,
    output router_pkg::port_vec_t send,
    output router_pkg::port_idx_t sel_input [router_pkg::NUM_PORTS]);

   import router_pkg::*;

   //--------------------------------------------------
   // per-output state
   //--------------------------------------------------

   // round-robin pointer, lock flag and owning input per output
   port_idx_t rr_ptr [NUM_PORTS];
   port_vec_t lock_q;
   port_idx_t lock_in_q [NUM_PORTS];

   // grant_col[i][o] is set when output o serves input i this cycle
   port_vec_t grant_col [NUM_PORTS];

   function automatic port_idx_t rr_next(port_idx_t idx);
      return (idx == port_idx_t'(NUM_PORTS - 1)) ? '0 : idx + 1'b1;
   endfunction

   //--------------------------------------------------
   // output arbitration
   //--------------------------------------------------

   for (genvar o = 0; o < NUM_PORTS; o++)
   begin : g_out
      port_idx_t pick;
      logic      found;

      // first requester at or after the pointer
      always_comb
      begin
         int idx;
         pick  = rr_ptr[o];
         found = 1'b0;
         for (int k = 0; k < NUM_PORTS; k++)
         begin
            idx = int'(rr_ptr[o]) + k;
            if (idx >= NUM_PORTS)
               idx = idx - NUM_PORTS;
            if (!found && request[idx][o])
            begin
               found = 1'b1;
               pick  = port_idx_t'(idx);
            end
         end
      end

      // a locked output only listens to its owner
      assign sel_input[o] = lock_q[o] ? lock_in_q[o] : pick;
      assign send[o] = (lock_q[o] ? request[lock_in_q[o]][o] : found) && credit_ok[o];
   end

   //--------------------------------------------------
   // grant back to inputs
   //--------------------------------------------------

   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_in
      for (genvar o = 0; o < NUM_PORTS; o++)
      begin : g_col
         assign grant_col[i][o] = send[o] && (sel_input[o] == port_idx_t'(i));
      end

      // grant means dequeue
      assign grant[i] = |grant_col[i];

      // one-hot requests must never produce a double dequeue
      a_single_grant: assert property (@(posedge clk) disable iff (rst)
                                       $onehot0(grant_col[i]))
         else $error("input granted by more than one output");
   end

   //--------------------------------------------------
   // lock and pointer update
   //--------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         lock_q <= '0;
         for (int o = 0; o < NUM_PORTS; o++)
            rr_ptr[o] <= '0;
      end
      else
      begin
         for (int o = 0; o < NUM_PORTS; o++)
         begin
            if (send[o])
            begin
               // tail releases the output and advances fairness
               if (tail_flit[sel_input[o]])
               begin
                  lock_q[o] <= 1'b0;
                  rr_ptr[o] <= rr_next(sel_input[o]);
               end
               else
                  lock_q[o] <= 1'b1;
            end
         end
      end
   end

   // owner is only read while the lock flag is set
   always_ff @(posedge clk)
   begin
      for (int o = 0; o < NUM_PORTS; o++)
      begin
         if (send[o] && !tail_flit[sel_input[o]])
            lock_in_q[o] <= sel_input[o];
      end
   end

endmodule

// File: verilog/output_port.sv
// router output port: crossbar column select, output register and credit counter
module output_port
  #(parameter int flit_data_width = 32,
    parameter int buffer_size = 4)
   (input  logic                       clk,
    input  logic                       rst,
    input  logic                       send,
    input  router_pkg::port_idx_t      sel_input,
    input  router_pkg::port_vec_t      head_flit,
    input  router_pkg::port_vec_t      tail_flit,
    input  logic [flit_data_width-1:0] flit_data [router_pkg::NUM_PORTS],
    input  logic                       credit_in,
    output logic                       credit_ok,
    output logic                       out_valid,
    output logic                       out_head,
    output logic                       out_tail,
    output logic [flit_data_width-1:0] out_data);

   import router_pkg::*;

   localparam int cnt_width = $clog2(buffer_size + 1);

   //--------------------------------------------------
   // crossbar column and output register
   //--------------------------------------------------

   // framing bits are control, cleared on reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
         out_head  <= 1'b0;
         out_tail  <= 1'b0;
      end
      else
      begin
         out_valid <= send;
         out_head  <= send && head_flit[sel_input];
         out_tail  <= send && tail_flit[sel_input];
      end
   end

   // payload only qualified by out_valid
   always_ff @(posedge clk)
   begin
      if (send)
         out_data <= flit_data[sel_input];
   end

   //--------------------------------------------------
   // downstream credits
   //--------------------------------------------------

   // free slots in the next router's input buffer
   logic [cnt_width-1:0] credit_cnt;

   always_ff @(posedge clk)
   begin
      if (rst)
         credit_cnt <= cnt_width'(buffer_size);
      else
      begin
         // send and return together cancel out
         case ({send, credit_in})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   assign credit_ok = (credit_cnt != '0);

   //--------------------------------------------------
   // checks
   //--------------------------------------------------

   // allocator must respect the credit level
   a_no_send_empty: assert property (@(posedge clk) disable iff (rst)
                                     send |-> credit_cnt != '0)
      else $error("flit sent without downstream credit");

   // downstream returned more credits than it owns
   a_credit_bound: assert property (@(posedge clk) disable iff (rst)
                                    credit_in && !send |-> credit_cnt < cnt_width'(buffer_size))
      else $error("credit counter overflow");

endmodule

// File: verilog/router_top.sv
// five-port wormhole mesh router with credit flow control and x-first routing
module router_top
  #(parameter int flit_data_width = 32,
    parameter int buffer_size = 4,
    parameter int dim_addr_width = 2)
   (input  logic                          clk,
    input  logic                          rst,
    input  logic [dim_addr_width-1:0]     router_x,
    input  logic [dim_addr_width-1:0]     router_y,
    input  logic [router_pkg::NUM_PORTS-1:0] in_valid,
    input  logic [router_pkg::NUM_PORTS-1:0] in_head,
    input  logic [router_pkg::NUM_PORTS-1:0] in_tail,
    input  logic [flit_data_width-1:0]    in_data [router_pkg::NUM_PORTS],
    output logic [router_pkg::NUM_PORTS-1:0] credit_out,
    output logic [router_pkg::NUM_PORTS-1:0] out_valid,
    output logic [router_pkg::NUM_PORTS-1:0] out_head,
    output logic [router_pkg::NUM_PORTS-1:0] out_tail,
    output logic [flit_data_width-1:0]    out_data [router_pkg::NUM_PORTS],
    input  logic [router_pkg::NUM_PORTS-1:0] credit_in);

   import router_pkg::*;

   // input side toward allocator and crossbar
   port_vec_t                  request [NUM_PORTS];
   port_vec_t                  head_flit;
   port_vec_t                  tail_flit;
   logic [flit_data_width-1:0] flit_data [NUM_PORTS];

   // allocator decisions and credit state
   port_vec_t grant;
   port_vec_t send;
   port_vec_t credit_ok;
   port_idx_t sel_input [NUM_PORTS];

   //--------------------------------------------------
   // input ports
   //--------------------------------------------------

   for (genvar i = 0; i < NUM_PORTS; i++)
   begin : g_ip
      input_port
        #(.flit_data_width(flit_data_width),
          .buffer_size(buffer_size),
          .dim_addr_width(dim_addr_width))
      i_ip
        (.clk(clk),
         .rst(rst),
         .router_x(router_x),
         .router_y(router_y),
         .in_valid(in_valid[i]),
         .in_head(in_head[i]),
         .in_tail(in_tail[i]),
         .in_data(in_data[i]),
         .grant(grant[i]),
         .request(request[i]),
         .head_flit(head_flit[i]),
         .tail_flit(tail_flit[i]),
         .flit_data(flit_data[i]),
         .credit_out(credit_out[i]));
   end

   //--------------------------------------------------
   // switch allocator
   //--------------------------------------------------

   switch_alloc i_sa
     (.clk(clk),
      .rst(rst),
      .request(request),
      .tail_flit(tail_flit),
      .credit_ok(credit_ok),
      .grant(grant),
      .send(send),
      .sel_input(sel_input));

   //--------------------------------------------------
   // output ports, each one crossbar column
   //--------------------------------------------------

   for (genvar o = 0; o < NUM_PORTS; o++)
   begin : g_op
      output_port
        #(.flit_data_width(flit_data_width),
          .buffer_size(buffer_size))
      i_op
        (.clk(clk),
         .rst(rst),
         .send(send[o]),
         .sel_input(sel_input[o]),
         .head_flit(head_flit),
         .tail_flit(tail_flit),
         .flit_data(flit_data),
         .credit_in(credit_in[o]),
         .credit_ok(credit_ok[o]),
         .out_valid(out_valid[o]),
         .out_head(out_head[o]),
         .out_tail(out_tail[o]),
         .out_data(out_data[o]));
   end

endmodule

// File: verification/clk_rst_gen.sv
// testbench clock and reset source: free running clock, reset held for a few cycles
module clk_rst_gen
  #(parameter int half_period = 10,
    parameter int reset_cycles = 4)
   (output logic clk,
    output logic rst);

   // period is twice the half period
   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // reset drops a little after the last reset edge
   initial
   begin
      rst = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst = 1'b0;
   end

endmodule

// File: verification/router_tb.sv
// directed testbench for the five-port wormhole mesh router
module router_tb;

   import router_pkg::*;

   localparam int flit_data_width = 32;
   localparam int buffer_size = 4;
   localparam int dim_addr_width = 2;

   // coordinates given to the DUT
   localparam int node_x = 1;
   localparam int node_y = 1;

   // all six tests together need a few hundred cycles
   localparam int unsigned cycle_limit = 2000;

   // one flit seen on an output channel
   typedef struct packed
   {
      port_idx_t   port;
      logic        head;
      logic        tail;
      logic [31:0] edge_no;
      logic [31:0] data;
   } obs_t;

   logic clk;
   logic rst;

   port_vec_t                  in_valid = '0;
   port_vec_t                  in_head = '0;
   port_vec_t                  in_tail = '0;
   logic [flit_data_width-1:0] in_data [NUM_PORTS];
   port_vec_t                  credit_in = '0;
   port_vec_t                  credit_out;
   port_vec_t                  out_valid;
   port_vec_t                  out_head;
   port_vec_t                  out_tail;
   logic [flit_data_width-1:0] out_data [NUM_PORTS];

   // bookkeeping for monitor, upstream credits and downstream credit model
   logic [31:0] cycle_cnt = '0;
   obs_t        obs_q [$];
   int unsigned credit_seen [NUM_PORTS];
   int unsigned sent_cnt [NUM_PORTS];
   port_vec_t   credit_hold = '0;
   int unsigned release_req [NUM_PORTS];
   int unsigned release_done [NUM_PORTS];

   clk_rst_gen i_clk_rst
     (.clk(clk),
      .rst(rst));

   router_top
     #(.flit_data_width(flit_data_width),
       .buffer_size(buffer_size),
       .dim_addr_width(dim_addr_width))
   i_dut
     (.clk(clk),
      .rst(rst),
      .router_x(dim_addr_width'(node_x)),
      .router_y(dim_addr_width'(node_y)),
      .in_valid(in_valid),
      .in_head(in_head),
      .in_tail(in_tail),
      .in_data(in_data),
      .credit_out(credit_out),
      .out_valid(out_valid),
      .out_head(out_head),
      .out_tail(out_tail),
      .out_data(out_data),
      .credit_in(credit_in));

   //--------------------------------------------------
   // watchdog, monitor and downstream credit model
   //--------------------------------------------------

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("timeout: tests did not complete within %0d cycles", cycle_limit);
         $display("Errors found");
         $fatal(1, "watchdog expired");
      end
   end

   // outputs sampled mid cycle and tagged with the edge that samples them
   always @(negedge clk)
   begin
      obs_t ob;
      if (!rst)
      begin
         for (int p = 0; p < NUM_PORTS; p++)
         begin
            if (out_valid[p])
            begin
               ob.port    = port_idx_t'(p);
               ob.head    = out_head[p];
               ob.tail    = out_tail[p];
               ob.edge_no = cycle_cnt + 1;
               ob.data    = out_data[p];
               obs_q.push_back(ob);
            end
            if (credit_out[p])
               credit_seen[p]++;
         end
      end
   end

   // downstream node returns a credit per flit unless held back
   always @(posedge clk)
   begin
      #1;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         if (!credit_hold[p])
            credit_in[p] = out_valid[p];
         else if (release_done[p] < release_req[p])
         begin
            credit_in[p] = 1'b1;
            release_done[p]++;
         end
         else
            credit_in[p] = 1'b0;
      end
   end

   //--------------------------------------------------
   // helpers
   //--------------------------------------------------

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at time %0t: %s", $time, msg);
      $display("Errors found");
      $fatal(1, "stopping at first failure");
   endtask

   // x first, then y, then the local node
   function automatic int expected_port(input int dx, input int dy);
      if (dx > node_x)
         return int'(PORT_XPOS);
      if (dx < node_x)
         return int'(PORT_XNEG);
      if (dy > node_y)
         return int'(PORT_YPOS);
      if (dy < node_y)
         return int'(PORT_YNEG);
      return int'(PORT_LOCAL);
   endfunction

   // random upper half, then sequence, source and destination fields
   function automatic logic [31:0] make_data(input int src, input int seq,
                                             input int dx, input int dy);
      logic [31:0] r;
      r = $urandom;
      return {r[31:16], seq[7:0], 1'b0, src[2:0], dy[1:0], dx[1:0]};
   endfunction

   // upstream may only hold buffer_size uncredited flits
   function automatic bit can_send(input int p);
      return (sent_cnt[p] - credit_seen[p]) < buffer_size;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
      in_valid = '0;
      in_head  = '0;
      in_tail  = '0;
   endtask

   // drives one flit for the coming edge
   task automatic put_flit(input int p, input logic head, input logic tail,
                           input logic [31:0] data);
      in_valid[p] = 1'b1;
      in_head[p]  = head;
      in_tail[p]  = tail;
      in_data[p]  = data;
      sent_cnt[p]++;
   endtask

   function automatic int count_obs(input int p, input int base);
      int n = 0;
      for (int i = base; i < obs_q.size(); i++)
         if (obs_q[i].port == port_idx_t'(p))
            n++;
      return n;
   endfunction

   function automatic obs_t nth_obs(input int p, input int base, input int n);
      int k = 0;
      for (int i = base; i < obs_q.size(); i++)
      begin
         if (obs_q[i].port == port_idx_t'(p))
         begin
            if (k == n)
               return obs_q[i];
            k++;
         end
      end
      return '0;
   endfunction

   task automatic wait_obs(input int p, input int base, input int n);
      while (count_obs(p, base) < n)
         next_cycle();
   endtask

   task automatic check_flit(input obs_t ob, input logic head, input logic tail,
                             input logic [31:0] data);
      assert (ob.head == head && ob.tail == tail)
      else
         report_mismatch($sformatf("port %0d framing h%0b t%0b, expected h%0b t%0b",
                                   ob.port, ob.head, ob.tail, head, tail));
      assert (ob.data == data)
      else
         report_mismatch($sformatf("port %0d data %h, expected %h", ob.port, ob.data, data));
   endtask

   //--------------------------------------------------
   // tests
   //--------------------------------------------------

   task automatic test_reset();
      while (rst)
         @(posedge clk);
      repeat (8)
      begin
         @(negedge clk);
         assert (out_valid == '0 && credit_out == '0)
         else
            report_mismatch($sformatf("after reset out_valid %b credit_out %b",
                                      out_valid, credit_out));
      end
   endtask

   // local port injects one destination per route class
   task automatic test_routing();
      int          dest_x [5] = '{2, 0, 1, 1, 1};
      int          dest_y [5] = '{1, 1, 2, 0, 1};
      int          base;
      int          exp_port;
      logic [31:0] data;
      logic [31:0] sent_edge;
      obs_t        ob;
      for (int k = 0; k < 5; k++)
      begin
         base     = obs_q.size();
         exp_port = expected_port(dest_x[k], dest_y[k]);
         data     = make_data(int'(PORT_LOCAL), k, dest_x[k], dest_y[k]);
         next_cycle();
         put_flit(int'(PORT_LOCAL), 1'b1, 1'b1, data);
         sent_edge = cycle_cnt + 1;
         next_cycle();
         while (obs_q.size() < base + 1)
            next_cycle();
         ob = obs_q[base];
         assert (int'(ob.port) == exp_port)
         else
            report_mismatch($sformatf("flit left on port %0d, expected %0d", ob.port, exp_port));
         check_flit(ob, 1'b1, 1'b1, data);
         assert (ob.edge_no == sent_edge + 2)
         else
            report_mismatch($sformatf("flit out at edge %0d, expected %0d",
                                      ob.edge_no, sent_edge + 2));
         repeat (3) next_cycle();
         assert (obs_q.size() == base + 1)
         else
            report_mismatch("extra flit on an output during routing test");
      end
   endtask

   // two three-flit packets race for the local output
   task automatic test_packets();
      logic [31:0] pkt_a [3];
      logic [31:0] pkt_b [3];
      int          base;
      obs_t        first;
      obs_t        ob;
      base = obs_q.size();
      for (int f = 0; f < 3; f++)
      begin
         pkt_a[f] = make_data(int'(PORT_XNEG), f, node_x, node_y);
         pkt_b[f] = make_data(int'(PORT_YNEG), f, node_x, node_y);
         next_cycle();
         put_flit(int'(PORT_XNEG), f == 0, f == 2, pkt_a[f]);
         put_flit(int'(PORT_YNEG), f == 0, f == 2, pkt_b[f]);
      end
      next_cycle();
      wait_obs(int'(PORT_LOCAL), base, 6);
      first = nth_obs(int'(PORT_LOCAL), base, 0);
      for (int n = 0; n < 6; n++)
      begin
         ob = nth_obs(int'(PORT_LOCAL), base, n);
         check_flit(ob, (n % 3) == 0, (n % 3) == 2, (n < 3) ? pkt_a[n] : pkt_b[n - 3]);
         // no gap inside the packet stream
         assert (ob.edge_no == first.edge_no + n)
         else
            report_mismatch($sformatf("flit %0d out at edge %0d, expected %0d",
                                      n, ob.edge_no, first.edge_no + n));
      end
   endtask

   // downstream stalls so only buffer_size flits may pass
   task automatic test_backpressure();
      logic [31:0] pkt [buffer_size + 2];
      int          base;
      obs_t        ob;
      base = obs_q.size();
      credit_hold[PORT_XPOS] = 1'b1;
      for (int n = 0; n < buffer_size + 2; n++)
      begin
         pkt[n] = make_data(int'(PORT_LOCAL), n, 2, node_y);
         next_cycle();
         while (!can_send(int'(PORT_LOCAL)))
            next_cycle();
         put_flit(int'(PORT_LOCAL), 1'b1, 1'b1, pkt[n]);
      end
      repeat (12) next_cycle();
      assert (count_obs(int'(PORT_XPOS), base) == buffer_size)
      else
         report_mismatch($sformatf("%0d flits passed without credit, expected %0d",
                                   count_obs(int'(PORT_XPOS), base), buffer_size));
      release_req[PORT_XPOS] += buffer_size + 2;
      wait_obs(int'(PORT_XPOS), base, buffer_size + 2);
      for (int n = 0; n < buffer_size + 2; n++)
      begin
         ob = nth_obs(int'(PORT_XPOS), base, n);
         check_flit(ob, 1'b1, 1'b1, pkt[n]);
      end
      while (release_done[PORT_XPOS] < release_req[PORT_XPOS])
         next_cycle();
      next_cycle();
      credit_hold[PORT_XPOS] = 1'b0;
   endtask

   // one credit back per flit that left the input
   task automatic test_credit_return();
      int unsigned credit_before;
      int          base;
      base          = obs_q.size();
      credit_before = credit_seen[PORT_YPOS];
      for (int n = 0; n < 8; n++)
      begin
         next_cycle();
         while (!can_send(int'(PORT_YPOS)))
            next_cycle();
         put_flit(int'(PORT_YPOS), 1'b1, 1'b1, make_data(int'(PORT_YPOS), n, 0, node_y));
      end
      next_cycle();
      wait_obs(int'(PORT_XNEG), base, 8);
      repeat (3) next_cycle();
      assert (count_obs(int'(PORT_XNEG), base) == 8)
      else
         report_mismatch("wrong number of flits delivered in credit test");
      assert (credit_seen[PORT_YPOS] - credit_before == 8)
      else
         report_mismatch($sformatf("%0d credit pulses for 8 flits",
                                   credit_seen[PORT_YPOS] - credit_before));
   endtask

   // two inputs keep the y minus output busy with single-flit packets
   task automatic test_fairness();
      localparam int rounds = 10;
      int          base;
      int          na;
      int          nb;
      int          seq_a;
      int          seq_b;
      logic [2:0]  src;
      logic [2:0]  prev_src;
      obs_t        ob;
      base  = obs_q.size();
      na    = 0;
      nb    = 0;
      seq_a = 0;
      seq_b = 0;
      while (na < rounds || nb < rounds)
      begin
         next_cycle();
         if (na < rounds && can_send(int'(PORT_XPOS)))
         begin
            put_flit(int'(PORT_XPOS), 1'b1, 1'b1, make_data(int'(PORT_XPOS), na, node_x, 0));
            na++;
         end
         if (nb < rounds && can_send(int'(PORT_YPOS)))
         begin
            put_flit(int'(PORT_YPOS), 1'b1, 1'b1, make_data(int'(PORT_YPOS), nb, node_x, 0));
            nb++;
         end
      end
      next_cycle();
      wait_obs(int'(PORT_YNEG), base, 2 * rounds);
      prev_src = '0;
      for (int n = 0; n < 2 * rounds; n++)
      begin
         ob  = nth_obs(int'(PORT_YNEG), base, n);
         src = ob.data[6:4];
         if (n > 0)
            assert (src != prev_src)
            else
               report_mismatch($sformatf("input %0d served twice in a row at flit %0d", src, n));
         // per source the sequence must stay in order
         if (src == PORT_XPOS)
         begin
            assert (int'(ob.data[15:8]) == seq_a)
            else
               report_mismatch($sformatf("x plus seq %0d, expected %0d", ob.data[15:8], seq_a));
            seq_a++;
         end
         else
         begin
            assert (src == PORT_YPOS && int'(ob.data[15:8]) == seq_b)
            else
               report_mismatch($sformatf("src %0d seq %0d, expected y plus seq %0d",
                                         src, ob.data[15:8], seq_b));
            seq_b++;
         end
         prev_src = src;
      end
   endtask

   //--------------------------------------------------
   // test sequence
   //--------------------------------------------------

   initial
   begin
      void'($urandom(32'h6390));
      for (int p = 0; p < NUM_PORTS; p++)
         in_data[p] = '0;
      test_reset();
      test_routing();
      test_packets();
      test_backpressure();
      test_credit_return();
      test_fairness();
      repeat (5) next_cycle();
      $display("No errors");
      $finish;
   end

endmodule

// File: vcr_router.f
verilog/router_pkg.sv
verilog/input_port.sv
verilog/switch_alloc.sv
verilog/output_port.sv
verilog/router_top.sv
verification/clk_rst_gen.sv
verification/router_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the router testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module router_tb \
   -f vcr_router.f -o router_sim

out=$(./obj_dir/router_sim 2>&1 || true)
printf '%s\n' "$out"

# the run passes only when the testbench printed its pass line
printf '%s\n' "$out" | grep -q "^No errors$"
